//--- Bender.yml
package:
  name: cnn_core

sources:
  # rtl, package first
  - design/cnn_pkg.sv
  - design/cnn_kernel_if.sv
  - design/cnn_kernel.sv
  - design/cnn_acc_ci.sv
  - design/cnn_ctrl.sv
  - design/cnn_core.sv
  - target: simulation
    files:
      - verif/cnn_core_assert.sv
      - verif/cnn_core_tb.sv

//--- design/cnn_acc_ci.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_acc_ci (
    input  wire logic                        clk,
    input  wire logic                        reset_n,
    input  wire logic signed [cnn_pkg::B_BW-1:0] i_bias,
    cnn_kernel_if.acc                        acc_if [cnn_pkg::CI],
    output logic                             o_ot_valid,
    output logic [cnn_pkg::O_F_BW-1:0]       o_ot_fmap
);
    import cnn_pkg::*;

    // pull channel results out of the interface array
    logic signed [AK_BW-1:0] ch_acc [CI];

    for (genvar c = 0; c < CI; c++) begin : gen_ch
        assign ch_acc[c] = acc_if[c].ot_acc;
    end

    // ========================================
    // stage 1, channel sum plus bias
    // ========================================
    logic signed [ACI_BW-1:0] ci_sum;
    logic signed [O_F_BW-1:0] pre_act;
    logic signed [O_F_BW-1:0] r_pre_act;

    always_comb begin
        ci_sum = '0;
        for (int c = 0; c < CI; c++) begin
            ci_sum = ci_sum + {{(ACI_BW-AK_BW){ch_acc[c][AK_BW-1]}}, ch_acc[c]};
        end
        pre_act = {{(O_F_BW-ACI_BW){ci_sum[ACI_BW-1]}}, ci_sum}
                + {{(O_F_BW-B_BW){i_bias[B_BW-1]}}, i_bias};
    end

    // channels run in lockstep, channel 0 speaks for all
    always_ff @(posedge clk) begin
        if (acc_if[0].ot_valid) begin
            r_pre_act <= pre_act;
        end
    end

    // ========================================
    // stage 2, relu
    // ========================================
    logic [LAT_CORE-LAT_KERNEL-1:0] vld_sr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_sr    <= '0;
            o_ot_fmap <= '0;
        end else begin
            vld_sr <= {vld_sr[LAT_CORE-LAT_KERNEL-2:0], acc_if[0].ot_valid};
            if (vld_sr[0]) begin
                // clamp negatives, pass the rest
                o_ot_fmap <= r_pre_act[O_F_BW-1] ? '0 : r_pre_act;
            end
        end
    end

    assign o_ot_valid = vld_sr[LAT_CORE-LAT_KERNEL-1];

endmodule

`default_nettype wire

//--- design/cnn_core.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_core (
    input  wire logic                                   clk,
    input  wire logic                                   reset_n,
    // window stream
    input  wire logic                                   i_in_valid,
    input  wire logic [cnn_pkg::CI*cnn_pkg::WIN_N*cnn_pkg::I_F_BW-1:0] i_in_fmap,
    // configuration writes
    input  wire logic                                   i_cfg_wr,
    input  wire logic [cnn_pkg::CFG_ADDR_BW-1:0]        i_cfg_addr,
    input  wire logic [cnn_pkg::B_BW-1:0]               i_cfg_data,
    // result
    output logic                                        o_ot_valid,
    output logic [cnn_pkg::O_F_BW-1:0]                  o_ot_fmap,
    output logic                                        o_cfg_reject
);
    import cnn_pkg::*;

    // one link per input channel
    cnn_kernel_if ch_if [CI] ();

    logic signed [B_BW-1:0] bias;

    // ========================================
    // config and window fanout
    // ========================================
    cnn_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_fmap    (i_in_fmap),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_cfg_reject (o_cfg_reject),
        .o_bias       (bias),
        .ch_if        (ch_if)
    );

    // ========================================
    // per-channel mac
    // ========================================
    for (genvar c = 0; c < CI; c++) begin : gen_kernel
        cnn_kernel u_kernel (
            .clk     (clk),
            .reset_n (reset_n),
            .kif     (ch_if[c])
        );
    end

    // channel sum, bias, relu
    cnn_acc_ci u_acc (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_bias     (bias),
        .acc_if     (ch_if),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap)
    );

endmodule

`default_nettype wire

//--- design/cnn_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_ctrl (
    input  wire logic                                   clk,
    input  wire logic                                   reset_n,
    input  wire logic                                   i_in_valid,
    input  wire logic [cnn_pkg::CI*cnn_pkg::WIN_N*cnn_pkg::I_F_BW-1:0] i_in_fmap,
    input  wire logic                                   i_cfg_wr,
    input  wire logic [cnn_pkg::CFG_ADDR_BW-1:0]        i_cfg_addr,
    input  wire logic [cnn_pkg::B_BW-1:0]               i_cfg_data,
    output logic                                        o_cfg_reject,
    output logic signed [cnn_pkg::B_BW-1:0]             o_bias,
    cnn_kernel_if.ctrl                                  ch_if [cnn_pkg::CI]
);
    import cnn_pkg::*;

    // wide enough to hold LAT_CORE
    typedef logic [$clog2(LAT_CORE+1)-1:0] flight_t;

    // ========================================
    // in-flight tracking
    // ========================================
    logic [LAT_CORE-1:0] win_sr;
    flight_t             flight_cnt;
    logic                win_done;
    logic                cfg_ok;

    // top bit marks the cycle the window leaves the core
    assign win_done = win_sr[LAT_CORE-1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win_sr     <= '0;
            flight_cnt <= '0;
        end else begin
            win_sr <= {win_sr[LAT_CORE-2:0], i_in_valid};
            // saturate at both ends
            if (i_in_valid && !win_done && flight_cnt != flight_t'(LAT_CORE)) begin
                flight_cnt <= flight_cnt + 1'b1;
            end else if (win_done && !i_in_valid && flight_cnt != '0) begin
                flight_cnt <= flight_cnt - 1'b1;
            end
        end
    end

    // no writes under a live window, nor beside a new one
    assign cfg_ok = (flight_cnt == '0) && !i_in_valid;

    // ========================================
    // weight and bias storage
    // ========================================
    logic [CI*WIN_N-1:0][W_BW-1:0] weight_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            weight_q     <= '0;
            o_bias       <= '0;
            o_cfg_reject <= 1'b0;
        end else begin
            o_cfg_reject <= i_cfg_wr && !cfg_ok;
            if (i_cfg_wr && cfg_ok) begin
                // weight bytes first, bias word right after
                if (i_cfg_addr < CFG_ADDR_BW'(BIAS_ADDR)) begin
                    weight_q[i_cfg_addr] <= i_cfg_data[W_BW-1:0];
                end else if (i_cfg_addr == CFG_ADDR_BW'(BIAS_ADDR)) begin
                    o_bias <= i_cfg_data;
                end
            end
        end
    end

    // ========================================
    // per-channel window fanout
    // ========================================
    for (genvar c = 0; c < CI; c++) begin : gen_ch
        assign ch_if[c].valid  = i_in_valid;
        assign ch_if[c].fmap   = i_in_fmap[c*WIN_N*I_F_BW +: WIN_N*I_F_BW];
        // tap k of channel c sits at address c*WIN_N+k
        assign ch_if[c].weight = weight_q[c*WIN_N +: WIN_N];
    end

endmodule

`default_nettype wire

//--- design/cnn_kernel.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_kernel (
    input  wire logic        clk,
    input  wire logic        reset_n,
    cnn_kernel_if.kernel     kif
);
    import cnn_pkg::*;

    // ========================================
    // valid pipeline
    // ========================================
    // bit 0 -> products held, bit 1 -> sum held
    logic [LAT_KERNEL-1:0] vld_sr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[LAT_KERNEL-2:0], kif.valid};
        end
    end

    // ========================================
    // stage 1, multiply
    // ========================================
    // pixel is unsigned, so zero extend before the signed multiply
    function automatic logic signed [M_BW-1:0] mul_tap(
        input logic [I_F_BW-1:0] f,
        input logic [W_BW-1:0]   w
    );
        logic signed [M_BW-1:0] f_ext;
        logic signed [M_BW-1:0] w_ext;
        f_ext = {{(M_BW-I_F_BW){1'b0}}, f};
        w_ext = {{(M_BW-W_BW){w[W_BW-1]}}, w};
        // low M_BW bits are exact, 255 * -128 still fits
        return f_ext * w_ext;
    endfunction

    logic signed [M_BW-1:0] r_prod [WIN_N];

    // tap k is row k/KX, column k%KX
    always_ff @(posedge clk) begin
        if (kif.valid) begin
            for (int k = 0; k < WIN_N; k++) begin
                r_prod[k] <= mul_tap(kif.fmap[k*I_F_BW +: I_F_BW],
                                     kif.weight[k*W_BW +: W_BW]);
            end
        end
    end

    // ========================================
    // stage 2, adder tree
    // ========================================
    logic signed [AK_BW-1:0] tree_sum;
    logic signed [AK_BW-1:0] r_sum;

    // sign extend every product to the full sum width
    always_comb begin
        tree_sum = '0;
        for (int k = 0; k < WIN_N; k++) begin
            tree_sum = tree_sum + {{(AK_BW-M_BW){r_prod[k][M_BW-1]}}, r_prod[k]};
        end
    end

    // only load when products are fresh
    always_ff @(posedge clk) begin
        if (vld_sr[0]) begin
            r_sum <= tree_sum;
        end
    end

    assign kif.ot_valid = vld_sr[LAT_KERNEL-1];
    assign kif.ot_acc   = r_sum;

endmodule

`default_nettype wire

//--- design/cnn_kernel_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cnn_kernel_if;
    import cnn_pkg::*;

    // window side, from controller
    logic                          valid;
    logic [WIN_N*I_F_BW-1:0]       fmap;
    logic [WIN_N*W_BW-1:0]         weight;

    // result side, from kernel
    logic                          ot_valid;
    logic signed [AK_BW-1:0]       ot_acc;

    // controller drives one window per valid cycle
    modport ctrl (
        output valid, fmap, weight
    );

    modport kernel (
        input  valid, fmap, weight,
        output ot_valid, ot_acc
    );

    // accumulator only sees the kernel result
    modport acc (
        input  ot_valid, ot_acc
    );

endinterface

`default_nettype wire

//--- design/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // ========================================
    // window geometry
    // ========================================
    localparam int KX    = 3;
    localparam int KY    = 3;
    localparam int CI    = 2;
    localparam int WIN_N = KX * KY;

    // ========================================
    // datapath widths
    // ========================================
    // unsigned pixel, signed weight and bias
    localparam int I_F_BW = 8;
    localparam int W_BW   = 8;
    localparam int B_BW   = 16;
    // one product, 9 bit zero-extended pixel times 8 bit weight
    localparam int M_BW   = 16;
    // nine products need 4 growth bits
    localparam int AK_BW  = M_BW + 4;
    // two channels add one bit
    localparam int ACI_BW = AK_BW + 1;
    // bias added on top
    localparam int O_F_BW = ACI_BW + 1;

    // ========================================
    // configuration map
    // ========================================
    localparam int CFG_ADDR_BW = 5;
    // addresses 0..17 are weights, channel major
    localparam int BIAS_ADDR   = CI * WIN_N;

    // pipeline depth
    localparam int LAT_KERNEL = 2;
    localparam int LAT_CORE   = 4;

endpackage

`default_nettype wire

//--- verif/cnn_core_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_core_assert (
    input wire logic                         clk,
    input wire logic                         reset_n,
    input wire logic                         i_in_valid,
    input wire logic                         i_cfg_wr,
    input wire logic                         o_ot_valid,
    input wire logic [cnn_pkg::O_F_BW-1:0]   o_ot_fmap,
    input wire logic                         o_cfg_reject
);
    import cnn_pkg::*;

    // fixed depth, no stalls anywhere
    a_latency: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid == $past(i_in_valid, LAT_CORE))
        else $error("o_ot_valid not aligned with i_in_valid");

    // relu output never negative
    a_relu: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> !o_ot_fmap[O_F_BW-1])
        else $error("o_ot_fmap negative while valid");

    // reject is the registered answer to a write
    a_reject: assert property (@(posedge clk) disable iff (!reset_n)
        o_cfg_reject |-> $past(i_cfg_wr))
        else $error("o_cfg_reject without a preceding write");

endmodule

bind cnn_core cnn_core_assert u_assert (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_in_valid   (i_in_valid),
    .i_cfg_wr     (i_cfg_wr),
    .o_ot_valid   (o_ot_valid),
    .o_ot_fmap    (o_ot_fmap),
    .o_cfg_reject (o_cfg_reject)
);

`default_nettype wire

//--- verif/cnn_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_core_tb;
    import cnn_pkg::*;

    localparam int FMAP_BW   = CI * WIN_N * I_F_BW;
    localparam int N_STEPS   = 21;
    localparam int DRAIN_TMO = 40;

    // step kinds
    localparam logic [1:0] K_CFG   = 2'd0;
    localparam logic [1:0] K_REJ   = 2'd1;
    localparam logic [1:0] K_BURST = 2'd2;

    // cnt is writes for K_CFG, windows for K_BURST
    // pat 1 on a K_CFG row takes the data from the LFSR
    typedef struct packed {
        logic [1:0]  kind;
        logic [4:0]  addr;
        logic [15:0] data;
        logic [7:0]  cnt;
        logic [1:0]  pat;
    } step_t;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic                   i_in_valid;
    logic [FMAP_BW-1:0]     i_in_fmap;
    logic                   i_cfg_wr;
    logic [CFG_ADDR_BW-1:0] i_cfg_addr;
    logic [B_BW-1:0]        i_cfg_data;
    logic                   o_ot_valid;
    logic [O_F_BW-1:0]      o_ot_fmap;
    logic                   o_cfg_reject;

    // reference model state
    logic [W_BW-1:0]   m_weight [CI*WIN_N];
    logic [B_BW-1:0]   m_bias;
    logic [O_F_BW-1:0] exp_val_q [$];
    int                exp_due_q [$];
    step_t             steps [N_STEPS];
    logic [31:0]       lfsr_state = 32'h510e_646f;
    logic              wr_q = 1'b0;
    int                cyc = 0;

    cnn_core dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_fmap    (i_in_fmap),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_ot_valid   (o_ot_valid),
        .o_ot_fmap    (o_ot_fmap),
        .o_cfg_reject (o_cfg_reject)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // cycle count, read before its update by the stimulus
    always @(posedge clk) begin
        cyc  <= cyc + 1;
        wr_q <= i_cfg_wr;
    end

    // ========================================
    // helpers
    // ========================================
    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic step_t make_step(input logic [1:0] kind, input int addr,
                                        input int data, input int cnt, input int pat);
        return {kind, 5'(addr), 16'(data), 8'(cnt), 2'(pat)};
    endfunction

    // window patterns: 0 zeros, 1 all 255, 2 ramp, 3 random
    function automatic logic [FMAP_BW-1:0] gen_window(input logic [1:0] pat);
        logic [FMAP_BW-1:0] w;
        logic [31:0]        r;
        for (int i = 0; i < CI*WIN_N; i++) begin
            case (pat)
                2'd0: w[i*I_F_BW +: I_F_BW] = '0;
                2'd1: w[i*I_F_BW +: I_F_BW] = 8'hff;
                2'd2: w[i*I_F_BW +: I_F_BW] = I_F_BW'(i + 1 + 10 * (i / WIN_N));
                default: begin
                    r = rand_bits(I_F_BW);
                    w[i*I_F_BW +: I_F_BW] = r[I_F_BW-1:0];
                end
            endcase
        end
        return w;
    endfunction

    // unsigned pixel times signed weight, all channels, plus bias, then relu
    function automatic logic [O_F_BW-1:0] model_out(input logic [FMAP_BW-1:0] w);
        int acc;
        int wt;
        acc = int'($signed(m_bias));
        for (int i = 0; i < CI*WIN_N; i++) begin
            wt  = int'($signed(m_weight[i]));
            acc = acc + int'(w[i*I_F_BW +: I_F_BW]) * wt;
        end
        return (acc < 0) ? '0 : O_F_BW'(acc);
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // polled at posedge, the monitor pops at negedge
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_val_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > DRAIN_TMO) begin
                $display("timeout: %0d outputs still pending after %0d cycles",
                         exp_val_q.size(), DRAIN_TMO);
                abort_run();
            end
        end
    endtask

    task automatic cfg_write(input int addr, input logic [15:0] data, input logic exp_rej);
        @(posedge clk);
        i_cfg_wr   <= 1'b1;
        i_cfg_addr <= CFG_ADDR_BW'(addr);
        i_cfg_data <= data;
        @(posedge clk);
        i_cfg_wr   <= 1'b0;
        @(negedge clk);
        check_value("o_cfg_reject", 32'(o_cfg_reject), 32'(exp_rej));
        // refused writes leave storage alone
        if (!exp_rej) begin
            if (addr < BIAS_ADDR) begin
                m_weight[addr] = data[W_BW-1:0];
            end else if (addr == BIAS_ADDR) begin
                m_bias = data;
            end
        end
    endtask

    // back to back windows, one per cycle
    task automatic send_burst(input int n, input logic [1:0] pat);
        logic [FMAP_BW-1:0] w;
        for (int i = 0; i < n; i++) begin
            w = gen_window(pat);
            @(posedge clk);
            i_in_valid <= 1'b1;
            i_in_fmap  <= w;
            exp_val_q.push_back(model_out(w));
            exp_due_q.push_back(cyc + 1 + LAT_CORE);
        end
        @(posedge clk);
        i_in_valid <= 1'b0;
    endtask

    // ========================================
    // output monitor
    // ========================================
    always @(negedge clk) begin
        if (reset_n === 1'b1) begin
            if (o_cfg_reject && !wr_q) begin
                $display("o_cfg_reject raised at %0t without a config write", $time);
                abort_run();
            end else if (o_ot_valid) begin
                if (exp_val_q.size() == 0) begin
                    $display("output at %0t with no window pending", $time);
                    abort_run();
                end else begin
                    check_value("o_ot_fmap", 32'(o_ot_fmap), 32'(exp_val_q.pop_front()));
                    check_value("output cycle", cyc, exp_due_q.pop_front());
                end
            end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc) begin
                $display("output missing at %0t, due in cycle %0d", $time, exp_due_q[0]);
                abort_run();
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin
        logic [15:0] d;
        logic [31:0] r;
        reset_n    = 1'b0;
        i_in_valid = 1'b0;
        i_in_fmap  = '0;
        i_cfg_wr   = 1'b0;
        i_cfg_addr = '0;
        i_cfg_data = '0;
        m_bias     = '0;
        for (int i = 0; i < CI*WIN_N; i++) begin
            m_weight[i] = '0;
        end

        // zero config straight out of reset
        steps[0]  = make_step(K_BURST, 0, 0, 1, 3);
        // known weights, 255 * -128 at ch0 centre tap
        steps[1]  = make_step(K_CFG, 0, 3, 18, 0);
        steps[2]  = make_step(K_CFG, 9, 100, 9, 0);
        steps[3]  = make_step(K_CFG, 4, 16'h0080, 1, 0);
        steps[4]  = make_step(K_CFG, 18, 1000, 1, 0);
        steps[5]  = make_step(K_BURST, 0, 0, 1, 2);
        steps[6]  = make_step(K_BURST, 0, 0, 1, 1);
        // relu clamp, then mixed signs staying positive
        steps[7]  = make_step(K_CFG, 0, 2, 18, 0);
        steps[8]  = make_step(K_CFG, 18, 16'h8000, 1, 0);
        steps[9]  = make_step(K_BURST, 0, 0, 1, 2);
        steps[10] = make_step(K_CFG, 9, 16'h00ff, 9, 0);
        steps[11] = make_step(K_CFG, 18, 500, 1, 0);
        steps[12] = make_step(K_BURST, 0, 0, 1, 2);
        // random weights, eight windows back to back
        steps[13] = make_step(K_CFG, 0, 0, 18, 1);
        steps[14] = make_step(K_CFG, 18, 200, 1, 0);
        steps[15] = make_step(K_BURST, 0, 0, 8, 3);
        // refused write while busy, old bias still used
        steps[16] = make_step(K_BURST, 0, 0, 4, 3);
        steps[17] = make_step(K_REJ, 18, 16'h7000, 1, 0);
        steps[18] = make_step(K_BURST, 0, 0, 2, 3);
        steps[19] = make_step(K_CFG, 18, 16'h7000, 1, 0);
        steps[20] = make_step(K_BURST, 0, 0, 2, 3);

        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("o_ot_valid", 32'(o_ot_valid), 32'd0);
        check_value("o_cfg_reject", 32'(o_cfg_reject), 32'd0);
        check_value("o_ot_fmap", 32'(o_ot_fmap), 32'd0);

        for (int s = 0; s < N_STEPS; s++) begin
            case (steps[s].kind)
                K_CFG: begin
                    // accepted writes need an empty pipeline
                    wait_drain();
                    for (int a = 0; a < int'(steps[s].cnt); a++) begin
                        d = steps[s].data;
                        if (steps[s].pat == 2'd1) begin
                            r = rand_bits(W_BW);
                            d = r[15:0];
                        end
                        cfg_write(int'(steps[s].addr) + a, d, 1'b0);
                    end
                end
                K_REJ: cfg_write(int'(steps[s].addr), steps[s].data, 1'b1);
                default: send_burst(int'(steps[s].cnt), steps[s].pat);
            endcase
        end

        wait_drain();
        // a few idle cycles to catch stray outputs
        repeat (2 * LAT_CORE) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/cnn_pkg.sv
design/cnn_kernel_if.sv
design/cnn_kernel.sv
design/cnn_acc_ci.sv
design/cnn_ctrl.sv
design/cnn_core.sv
verif/cnn_core_assert.sv
verif/cnn_core_tb.sv
